//--- gem_rx_pkg.sv
package gem_rx_pkg;

    // --------------------
    // Word and frame sizes
    // --------------------
    localparam int WORD_W      = 16;  // One decoded 8b/10b word
    localparam int KFLAG_W     = 2;   // K flags per word, one per byte
    localparam int FRAME_WORDS = 4;   // Comma word plus three data words
    localparam int RCV_W       = 56;  // Comma data byte and three data words
    localparam int KCHAR_W     = 8;   // Low byte of the comma word

    // --------------------
    // Link monitor
    // --------------------
    localparam int ERR_W       = 8;   // Link loss counter
    localparam int GOOD_FRAMES = 15;  // Clean frames before link_good

    // FC in the comma slot marks a latency trigger
    localparam logic [KCHAR_W-1:0] LT_TRIG_KCHAR = 8'hFC;

    // Error counter stops once its upper nibble gets here
    localparam logic [3:0] ERR_SAT_HI = 4'hE;

    // --------------------
    // Word views
    // --------------------

    // Comma word as sent by the GEM side
    typedef struct packed {
        logic [7:0]         data_byte;  // Extra payload byte, upper half
        logic [KCHAR_W-1:0] kchar;      // K character, lower half
    } gem_comma_word_t;

    // Same 16 bits, read either raw or as a comma word
    typedef union packed {
        logic [WORD_W-1:0] raw;    // Data words 1 to 3
        gem_comma_word_t   comma;  // Word 0 of the frame
    } gem_word_u;

    // Known K chars from the GEM side
    // BC FB F7 FD rotate in normal running
    // FC flags overflow and doubles as the latency trigger

endpackage

//--- gem_rx_word_if.sv
`timescale 1ns/1ps

// Decoded word stream plus frame phase, shared by the receive blocks
interface gem_rx_word_if;

    gem_rx_pkg::gem_word_u word;                          // Decoded word, one per clock
    logic [gem_rx_pkg::KFLAG_W-1:0] isk;                  // K flag per byte
    logic [gem_rx_pkg::KFLAG_W-1:0] notintable;           // Code violation per byte
    logic                           lossofsync;           // Decoder lost comma lock

    logic [gem_rx_pkg::FRAME_WORDS-1:0] cew;              // One-hot word position strobes
    logic                               frame_clr;        // Resync or sync not done

    // Phase generator sees the raw stream and drives the strobes
    modport phase (
        input  word,
        input  isk,
        output cew,
        output frame_clr
    );

    // Assembler and link monitor only listen
    modport sink (
        input word,
        input isk,
        input notintable,
        input lossofsync,
        input cew,
        input frame_clr
    );

endinterface

//--- gem_frame_phase.sv
`timescale 1ns/1ps

module gem_frame_phase (
    input  logic          GEM_RX_CLK160,
    input  logic          gem_rx_resetdone,
    input  logic          rx_sync_done,
    input  logic          ttc_resync,
    gem_rx_word_if.phase  rx
);

    logic comma_det;

    // --------------------
    // Comma and clear
    // --------------------

    // K flag on the low byte only
    assign comma_det = (rx.isk == 2'b01);

    // Shared by assembler and monitor
    assign rx.frame_clr = ttc_resync || !rx_sync_done;

    // --------------------
    // Word strobe chain
    // --------------------

    // Comma seen this cycle gives cew[1] on the next edge
    // then cew[2], cew[3] and cew[0] follow one per edge
    // so cew[0] lines up with the next comma when frames run back to back
    always_ff @(posedge GEM_RX_CLK160 or negedge gem_rx_resetdone) begin
        if (!gem_rx_resetdone) begin
            rx.cew <= '0;
        end else if (rx.frame_clr) begin
            rx.cew <= '0;  // Next comma restarts the phase
        end else begin
            rx.cew <= {rx.cew[2], rx.cew[1], comma_det, rx.cew[3]};
        end
    end

    // Back to back frames
    //   comma  -> cew[0]
    //   word 1 -> cew[1]
    //   word 2 -> cew[2]
    //   word 3 -> cew[3]
    // First comma after a clear has no cew[0]

endmodule

//--- gem_frame_assembler.sv
`timescale 1ns/1ps

module gem_frame_assembler (
    input  logic                                  GEM_RX_CLK160,
    input  logic                                  gem_rx_resetdone,
    gem_rx_word_if.sink                           rx,
    output logic [gem_rx_pkg::RCV_W-1:0]          rcv_data,
    output logic [gem_rx_pkg::KCHAR_W-1:0]        k_char,
    output logic [gem_rx_pkg::FRAME_WORDS-1:0]    nonzero_word,
    output logic                                  ltncy_trig
);

    // --------------------
    // Frame buffers
    // --------------------
    logic [7:0]                    w0_byte;   // Comma data byte
    logic [gem_rx_pkg::WORD_W-1:0] w1_word;   // First data word
    logic [gem_rx_pkg::WORD_W-1:0] w2_word;   // Second data word
    logic                          lt_pend;   // FC seen in this frame's comma

    // Payload capture, word 3 goes straight to rcv_data
    always_ff @(posedge GEM_RX_CLK160) begin
        if (rx.cew[0]) begin
            w0_byte <= rx.word.comma.data_byte;
        end else if (rx.cew[1]) begin
            w1_word <= rx.word.raw;
        end else if (rx.cew[2]) begin
            w2_word <= rx.word.raw;
        end
    end

    // --------------------
    // Published frame
    // --------------------
    always_ff @(posedge GEM_RX_CLK160 or negedge gem_rx_resetdone) begin
        if (!gem_rx_resetdone) begin
            rcv_data     <= '0;
            k_char       <= '0;
            nonzero_word <= '0;
            ltncy_trig   <= 1'b0;
            lt_pend      <= 1'b0;
        end else if (rx.frame_clr) begin
            rcv_data     <= '0;
            k_char       <= '0;
            nonzero_word <= '0;
            ltncy_trig   <= 1'b0;
            lt_pend      <= 1'b0;
        end else if (rx.cew[0]) begin
            // Comma slot read through the comma view
            k_char          <= rx.word.comma.kchar;
            lt_pend         <= (rx.word.comma.kchar == gem_rx_pkg::LT_TRIG_KCHAR);
            nonzero_word[0] <= |rx.word.comma.data_byte;
        end else if (rx.cew[1]) begin
            nonzero_word[1] <= |rx.word.raw;
        end else if (rx.cew[2]) begin
            nonzero_word[2] <= |rx.word.raw;
        end else if (rx.cew[3]) begin
            // Last data word completes the frame
            rcv_data        <= {rx.word.raw, w2_word, w1_word, w0_byte};
            ltncy_trig      <= lt_pend;
            nonzero_word[3] <= |rx.word.raw;
        end else begin
            // No strobe means no frame
            rcv_data     <= '0;
            nonzero_word <= '0;
            ltncy_trig   <= 1'b0;
        end
    end

    // rcv_data layout, MSB first
    //   [55:40] word 3
    //   [39:24] word 2
    //   [23:8]  word 1
    //   [7:0]   comma data byte

endmodule

//--- gem_link_monitor.sv
`timescale 1ns/1ps

module gem_link_monitor (
    input  logic                             GEM_RX_CLK160,
    input  logic                             gem_rx_resetdone,
    gem_rx_word_if.sink                      rx,
    output logic                             link_good,
    output logic                             link_had_err,
    output logic                             link_bad,
    output logic [gem_rx_pkg::ERR_W-1:0]     errcount
);

    logic [gem_rx_pkg::FRAME_WORDS-1:0] mon_in;     // Per word check results
    logic                               mon_rst;    // Last frame not clean
    logic [3:0]                         mon_count;  // Clean frames so far
    logic                               link_err;   // Link dropped at least once
    logic                               word_ok;    // Common word checks
    logic                               link_went_down;

    // --------------------
    // Word checks
    // --------------------

    // No sync loss and no code violations
    assign word_ok = !rx.lossofsync && (rx.notintable == 2'b00);

    assign link_went_down = link_good && mon_rst;  // Was up, last frame bad

    // --------------------
    // Status outputs
    // --------------------
    assign link_had_err = link_err || mon_rst;  // Also high before first good link
    assign link_bad     = errcount[gem_rx_pkg::ERR_W-1];

    always_ff @(posedge GEM_RX_CLK160 or negedge gem_rx_resetdone) begin
        if (!gem_rx_resetdone) begin
            mon_in    <= '0;
            mon_rst   <= 1'b1;
            mon_count <= '0;
            link_good <= 1'b0;
            link_err  <= 1'b0;
            errcount  <= '0;
        end else if (rx.frame_clr) begin
            mon_in    <= '0;
            mon_rst   <= 1'b1;  // Link counts as never alive again
            mon_count <= '0;
            link_good <= 1'b0;
            link_err  <= 1'b0;
            errcount  <= '0;
        end else begin
            if (rx.cew[0]) begin
                // Comma needs K on low byte and bits 7, 5, 4 set
                mon_in[0] <= word_ok && (rx.isk == 2'b01) &&
                             ({rx.word.comma.kchar[7], rx.word.comma.kchar[5:4]} == 3'b111);
            end else if (rx.cew[1]) begin
                mon_in[1] <= word_ok && (rx.isk == 2'b00) && !rx.cew[2] && !rx.cew[3];
            end else if (rx.cew[2]) begin
                mon_in[2] <= word_ok && (rx.isk == 2'b00) && !rx.cew[3];
            end else if (rx.cew[3]) begin
                mon_in[3] <= word_ok && (rx.isk == 2'b00);
            end else begin
                mon_in <= '0;  // Gap in strobes fails the frame
            end

            mon_rst <= (mon_in != '1);

            if (mon_rst)
                mon_count <= '0;
            else if (!link_good && rx.cew[3])
                mon_count <= mon_count + 4'd1;  // Holds once link is good

            link_good <= !mon_rst && (mon_count == 4'(gem_rx_pkg::GOOD_FRAMES));

            if (link_went_down)
                link_err <= 1'b1;  // Sticky until clear

            // Count link losses, stop near the top
            if (link_went_down && (errcount[gem_rx_pkg::ERR_W-1 -: 4] != gem_rx_pkg::ERR_SAT_HI))
                errcount <= errcount + 1'b1;
        end
    end

endmodule

//--- gem_fiber_rx.sv
`timescale 1ns/1ps

module gem_fiber_rx (
    input  logic                                  GEM_RX_CLK160,
    input  logic                                  gem_rx_resetdone,
    input  logic                                  rx_sync_done,
    input  logic                                  ttc_resync,
    input  logic [gem_rx_pkg::WORD_W-1:0]         gem_rx_data,
    input  logic [gem_rx_pkg::KFLAG_W-1:0]        gem_rx_isk,
    input  logic [gem_rx_pkg::KFLAG_W-1:0]        gem_rx_notintable,
    input  logic                                  gem_rx_lossofsync,
    output logic [gem_rx_pkg::RCV_W-1:0]          rcv_data,
    output logic [gem_rx_pkg::KCHAR_W-1:0]        k_char,
    output logic [gem_rx_pkg::FRAME_WORDS-1:0]    nonzero_word,
    output logic                                  ltncy_trig,
    output logic                                  link_good,
    output logic                                  link_had_err,
    output logic                                  link_bad,
    output logic [gem_rx_pkg::ERR_W-1:0]          errcount
);

    // --------------------
    // Decoded word stream
    // --------------------
    gem_rx_word_if rx_if ();

    assign rx_if.word.raw   = gem_rx_data;
    assign rx_if.isk        = gem_rx_isk;
    assign rx_if.notintable = gem_rx_notintable;
    assign rx_if.lossofsync = gem_rx_lossofsync;

    // --------------------
    // Receive pipeline
    // --------------------

    // Word position strobes and clear
    gem_frame_phase u_phase (
        .GEM_RX_CLK160    (GEM_RX_CLK160),
        .gem_rx_resetdone (gem_rx_resetdone),
        .rx_sync_done     (rx_sync_done),
        .ttc_resync       (ttc_resync),
        .rx               (rx_if.phase)
    );

    // 56-bit frame, K char, trigger
    gem_frame_assembler u_assembler (
        .GEM_RX_CLK160    (GEM_RX_CLK160),
        .gem_rx_resetdone (gem_rx_resetdone),
        .rx               (rx_if.sink),
        .rcv_data         (rcv_data),
        .k_char           (k_char),
        .nonzero_word     (nonzero_word),
        .ltncy_trig       (ltncy_trig)
    );

    // Link health
    gem_link_monitor u_monitor (
        .GEM_RX_CLK160    (GEM_RX_CLK160),
        .gem_rx_resetdone (gem_rx_resetdone),
        .rx               (rx_if.sink),
        .link_good        (link_good),
        .link_had_err     (link_had_err),
        .link_bad         (link_bad),
        .errcount         (errcount)
    );

endmodule

//--- tb_gem_fiber_rx.sv
`timescale 1ns/1ps

module tb_gem_fiber_rx;

    logic                               GEM_RX_CLK160;
    logic                               gem_rx_resetdone;
    logic                               rx_sync_done;
    logic                               ttc_resync;
    logic [gem_rx_pkg::WORD_W-1:0]      gem_rx_data;
    logic [gem_rx_pkg::KFLAG_W-1:0]     gem_rx_isk;
    logic [gem_rx_pkg::KFLAG_W-1:0]     gem_rx_notintable;
    logic                               gem_rx_lossofsync;
    logic [gem_rx_pkg::RCV_W-1:0]       rcv_data;
    logic [gem_rx_pkg::KCHAR_W-1:0]     k_char;
    logic [gem_rx_pkg::FRAME_WORDS-1:0] nonzero_word;
    logic                               ltncy_trig;
    logic                               link_good;
    logic                               link_had_err;
    logic                               link_bad;
    logic [gem_rx_pkg::ERR_W-1:0]       errcount;

    // One line of the tests file
    typedef struct {
        byte kind;   // F frame, S resync, E expect
        int  f1;     // K char or link_good
        int  f2;     // Word 1 or errcount
        int  f3;     // Word 2 or link_had_err
        int  f4;     // Word 3
        int  err;    // Word with not-in-table, 1 to 4, 0 for none
        int  count;  // Frames sent for this line
    } test_line_t;

    test_line_t                         tests[$];
    test_line_t                         exp_link;           // Link state due next falling edge
    logic                               link_pend  = 1'b0;
    logic                               frame_pend = 1'b0;
    logic [gem_rx_pkg::RCV_W-1:0]       exp_rcv;
    logic [gem_rx_pkg::KCHAR_W-1:0]     exp_k;
    logic [gem_rx_pkg::FRAME_WORDS-1:0] exp_nz;
    logic                               exp_lt;
    int                                 errors = 0;
    int                                 checks = 0;
    int                                 cycles = 0;
    int                                 cycle_limit = 100;
    int                                 frames_since_clr = 0;

    gem_fiber_rx dut0 (.*);

    // --------------------
    // Clock and run limit
    // --------------------
    always #2 GEM_RX_CLK160 = ~GEM_RX_CLK160;  // 4 ns period

    always @(posedge GEM_RX_CLK160) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
            $display("Checks run: %0d, errors: %0d", checks, errors);
            $display("Simulation failed");
            $finish;
        end
    end

    // --------------------
    // Tasks
    // --------------------
    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Falling edge, outputs from the last rising edge are settled here
    task automatic next_cycle();
        @(negedge GEM_RX_CLK160);
        if (frame_pend) begin
            check_value("rcv_data", rcv_data, exp_rcv);
            check_value("k_char", k_char, exp_k);
            check_value("nonzero_word", nonzero_word, exp_nz);
            check_value("ltncy_trig", ltncy_trig, exp_lt);
            frame_pend = 1'b0;
        end
        if (link_pend) begin
            check_value("link_good", link_good, exp_link.f1);
            check_value("errcount", errcount, exp_link.f2);
            check_value("link_had_err", link_had_err, exp_link.f3);
            check_value("link_bad", link_bad, exp_link.f2[gem_rx_pkg::ERR_W-1]);  // Counter MSB
            link_pend = 1'b0;
        end
    endtask

    task automatic drive_word(input logic [15:0] data, input logic [1:0] isk,
                              input logic [1:0] nit, input logic resync);
        next_cycle();
        gem_rx_data       = data;
        gem_rx_isk        = isk;
        gem_rx_notintable = nit;
        ttc_resync        = resync;
    endtask

    // Comma with a random data byte, then three data words
    task automatic send_frame(input logic [7:0] kchar, input logic [15:0] w1, w2, w3,
                              input int err);
        logic [7:0] dbyte;
        dbyte = 8'($urandom);
        drive_word({dbyte, kchar}, 2'b01, (err == 1) ? 2'b01 : 2'b00, 1'b0);
        drive_word(w1, 2'b00, (err == 2) ? 2'b01 : 2'b00, 1'b0);
        drive_word(w2, 2'b00, (err == 3) ? 2'b10 : 2'b00, 1'b0);
        drive_word(w3, 2'b00, (err == 4) ? 2'b11 : 2'b00, 1'b0);
        frames_since_clr++;
        if (frames_since_clr > 1) begin  // First frame after a clear only sets the phase
            exp_rcv    = {w3, w2, w1, dbyte};  // Word 3 on top, comma byte at the bottom
            exp_k      = kchar;
            exp_nz     = {|w3, |w2, |w1, |dbyte};
            exp_lt     = (kchar == 8'hFC);
            frame_pend = 1'b1;
        end
    endtask

    task automatic load_tests();
        int         fd;
        int         n;
        string      line;
        string      kind;
        test_line_t t;
        fd = $fopen("gem_rx_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open gem_rx_tests.txt");
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0)
                break;
            t.count = 0;
            n = $sscanf(line, "%s %h %h %h %h %d %d", kind, t.f1, t.f2, t.f3, t.f4,
                        t.err, t.count);
            if (n > 0 && kind.getc(0) != "#") begin  // Skip blank and comment lines
                t.kind = kind.getc(0);
                if (t.count < 1)
                    t.count = 1;
                tests.push_back(t);
            end
        end
        $fclose(fd);
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        int frames;
        int j;
        void'($urandom(73764));
        GEM_RX_CLK160     = 1'b0;
        gem_rx_resetdone  = 1'b0;
        rx_sync_done      = 1'b1;
        ttc_resync        = 1'b0;
        gem_rx_data       = '0;
        gem_rx_isk        = '0;
        gem_rx_notintable = '0;
        gem_rx_lossofsync = 1'b0;
        load_tests();
        frames = 0;
        foreach (tests[i])
            frames += (tests[i].kind == "F") ? tests[i].count : 1;
        cycle_limit = 4 * frames + 24;  // Four words per frame, plus reset and flush
        repeat (2) @(negedge GEM_RX_CLK160);
        gem_rx_resetdone = 1'b1;
        foreach (tests[i]) begin
            case (tests[i].kind)
                "F": begin
                    send_frame(8'(tests[i].f1), 16'(tests[i].f2), 16'(tests[i].f3),
                               16'(tests[i].f4), tests[i].err);
                    for (j = 1; j < tests[i].count; j++)
                        send_frame(8'(tests[i].f1), 16'($urandom), 16'($urandom),
                                   16'($urandom), 0);
                end
                "S": begin
                    drive_word(16'h0000, 2'b00, 2'b00, 1'b1);  // One cycle of ttc_resync
                    frames_since_clr = 0;
                end
                "E": begin
                    exp_link  = tests[i];
                    link_pend = 1'b1;
                end
                default: begin
                    errors++;
                    $display("Unknown line kind in gem_rx_tests.txt");
                end
            endcase
        end
        drive_word(16'h0000, 2'b00, 2'b00, 1'b0);  // Flush the last pending checks
        if (checks == 0) begin
            errors++;
            $display("No checks were run");
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- gem_rx_tests.txt
# F kchar word1 word2 word3 err count, S resync, E link_good errcount link_had_err
# err 1 to 4 marks that word not-in-table, count above 1 adds frames of random data
E 0 00 1
F BC 1111 2222 3333 0 1
F F7 0000 abcd 1234 0 1
F FC 5a5a 0000 a5a5 0 1
F FB dead beef 0000 0 1
F FC 0001 8000 7fff 0 1
F BC 0f0f f0f0 ffff 0 13
E 1 00 0
F FD 1234 5678 9abc 3 1
F BC cafe 0000 babe 0 1
E 0 01 1
F F7 2468 1357 0000 0 17
E 1 01 1
F FC 4444 5555 6666 1 1
F BC 7777 8888 9999 0 1
E 0 02 1
F FB 1010 2020 3030 0 16
E 1 02 1
S
E 0 00 1
F BC 3c3c c3c3 0000 0 17
F FC abab cdcd efef 0 1
E 1 00 0

//--- sim.f
gem_rx_pkg.sv
gem_rx_word_if.sv
gem_frame_phase.sv
gem_frame_assembler.sv
gem_link_monitor.sv
gem_fiber_rx.sv
tb_gem_fiber_rx.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_gem_fiber_rx
FILELIST = sim.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
